//--- common/descgen_params.svh
// descriptor generator constants: EtherType codes, class codes, header length, fixed fields
`ifndef DESCGEN_PARAMS_SVH
`define DESCGEN_PARAMS_SVH

//////////////////////////////
// EtherType codes
//////////////////////////////

`define DG_ETH_MAPPED       16'h1800    // mapped TSN frame
`define DG_ETH_TSMP         16'hFF01
`define DG_ETH_PTP          16'h88F7
`define DG_ETH_PCF          16'h891D

//////////////////////////////
// traffic classes
//////////////////////////////

// class sits in bits 7:5 of the head byte of a mapped frame
`define DG_CLASS_RC         3'd3
`define DG_CLASS_BE         3'd6

//////////////////////////////
// header and descriptor
//////////////////////////////

// bytes copied into the descriptor
`define DG_HDR_BYTES        6

`define DG_LOOKUP_EN        1'b1        // lookup enable bit
`define DG_OUTPORT_DEFAULT  9'd0        // outport field, filled by lookup

`endif

//--- common/descgen_pkg.sv
// descriptor generator types: stream, byte, buffer count, header, descriptor, counters, FSM state
package descgen_pkg;

    //////////////////////////////
    // data path widths
    //////////////////////////////

    typedef logic [8:0]  stream_word_t;  // bit 8 marks head and tail
    typedef logic [7:0]  octet_t;
    typedef logic [15:0] ethtype_t;
    typedef logic [47:0] hdr_bytes_t;    // first byte on top
    typedef logic [71:0] descriptor_t;

    //////////////////////////////
    // control widths
    //////////////////////////////

    typedef logic [8:0]  bufcnt_t;       // free buffer ids and thresholds
    typedef logic [31:0] discard_cnt_t;
    typedef logic [3:0]  inport_t;

    // frame tracking in header_capture
    typedef enum logic [1:0] {
        IDLE,
        IN_FRAME,
        DROP_WAIT   // abort cycle, frame already closed
    } cap_state_e;

endpackage

//--- descriptor/header_capture.sv
// header capture: frame tracking FSM, byte register and collection of the header bytes
`include "descgen_params.svh"

module header_capture (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  descgen_pkg::stream_word_t i_data,
    input  logic                      i_data_wr,
    output logic                      o_head,
    output descgen_pkg::stream_word_t o_byte,
    output logic                      o_byte_vld,
    output logic                      o_hdr_done,
    output descgen_pkg::hdr_bytes_t   o_hdr_bytes
);

    localparam int CNT_W = $clog2(`DG_HDR_BYTES + 1);
    localparam int HDR_W = 8 * `DG_HDR_BYTES;

    descgen_pkg::cap_state_e state;
    descgen_pkg::cap_state_e state_nxt;
    logic [CNT_W-1:0]        byte_cnt;      // saturates at header length
    logic [CNT_W-1:0]        hdr_idx;       // position of the current byte
    logic                    in_frame_wr;
    logic                    frame_byte;
    logic                    tail;

    //////////////////////////////
    // framing
    //////////////////////////////

    // a marked write starts a frame whenever none is open
    assign o_head      = i_data_wr && i_data[8] && (state != descgen_pkg::IN_FRAME);
    assign in_frame_wr = i_data_wr && (state == descgen_pkg::IN_FRAME);
    assign tail        = in_frame_wr && i_data[8];
    assign frame_byte  = o_head || in_frame_wr;
    assign hdr_idx     = o_head ? '0 : byte_cnt;

    always_comb begin
        state_nxt = state;
        case (state)
            descgen_pkg::IN_FRAME: begin
                if (tail)
                    state_nxt = descgen_pkg::IDLE;
                else if (!i_data_wr)
                    state_nxt = descgen_pkg::DROP_WAIT;   // write gap aborts
            end
            default: begin  // IDLE and DROP_WAIT both closed
                state_nxt = o_head ? descgen_pkg::IN_FRAME : descgen_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state      <= descgen_pkg::IDLE;
            byte_cnt   <= '0;
            o_byte_vld <= 1'b0;
            o_hdr_done <= 1'b0;
        end else begin
            state      <= state_nxt;
            o_byte_vld <= frame_byte;
            o_hdr_done <= frame_byte && (hdr_idx == CNT_W'(`DG_HDR_BYTES - 1));
            if (o_head)
                byte_cnt <= CNT_W'(1);
            else if (in_frame_wr && (byte_cnt < CNT_W'(`DG_HDR_BYTES)))
                byte_cnt <= byte_cnt + 1'b1;
        end
    end

    //////////////////////////////
    // payload
    //////////////////////////////

    always_ff @(posedge i_clk) begin
        if (frame_byte)
            o_byte <= i_data;
        // shift in until the header is complete
        if (frame_byte && (hdr_idx < CNT_W'(`DG_HDR_BYTES)))
            o_hdr_bytes <= {o_hdr_bytes[HDR_W-9:0], i_data[7:0]};
    end

endmodule

//--- admission/admission_ctrl.sv
// admission control: per-frame admit or discard decision, frame flag and discard counter
`include "descgen_params.svh"

module admission_ctrl (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_head,
    input  descgen_pkg::octet_t       i_head_byte,
    input  descgen_pkg::ethtype_t     i_eth_type,
    input  logic                      i_std_flag,
    input  descgen_pkg::bufcnt_t      i_free_bufid_num,
    input  descgen_pkg::bufcnt_t      i_hp_be_threshold,
    input  descgen_pkg::bufcnt_t      i_rc_threshold,
    input  descgen_pkg::bufcnt_t      i_lp_be_threshold,
    output logic                      o_accept,
    output logic                      o_std_flag,
    output descgen_pkg::discard_cnt_t o_discard_cnt
);

    logic       is_mapped;
    logic       is_hp;          // TSMP, PTP or PCF
    logic [2:0] tclass;
    logic       buf_empty;
    logic       under_hp;
    logic       under_rc;
    logic       under_lp;
    logic       drop;

    //////////////////////////////
    // classification
    //////////////////////////////

    assign is_mapped = (i_eth_type == `DG_ETH_MAPPED);
    assign is_hp     = (i_eth_type == `DG_ETH_TSMP) ||
                       (i_eth_type == `DG_ETH_PTP)  ||
                       (i_eth_type == `DG_ETH_PCF);
    assign tclass    = i_head_byte[7:5];

    assign buf_empty = (i_free_bufid_num == '0);
    assign under_hp  = (i_free_bufid_num <= i_hp_be_threshold);
    assign under_rc  = (i_free_bufid_num <= i_rc_threshold);
    assign under_lp  = (i_free_bufid_num <= i_lp_be_threshold);

    // discard table
    always_comb begin
        if (is_mapped) begin
            case (tclass)
                `DG_CLASS_RC: drop = under_rc || buf_empty;
                `DG_CLASS_BE: drop = under_rc || under_hp || buf_empty;
                default:      drop = buf_empty;     // time-critical
            endcase
        end else if (is_hp) begin
            drop = under_hp;
        end else begin
            drop = under_lp || buf_empty;           // low-priority BE
        end
    end

    //////////////////////////////
    // decision registers
    //////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_accept      <= 1'b0;
            o_std_flag    <= 1'b0;
            o_discard_cnt <= '0;
        end else if (i_head) begin
            o_accept   <= !drop;    // held for the whole frame
            o_std_flag <= is_mapped ? 1'b0 : i_std_flag;
            if (drop)
                o_discard_cnt <= o_discard_cnt + 1'b1;
        end
    end

endmodule

//--- logic/forward_stage.sv
// forward stage: gated byte output and descriptor assembly
`include "descgen_params.svh"

module forward_stage #(
    parameter descgen_pkg::inport_t INPORT = '0
) (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  descgen_pkg::stream_word_t i_byte,
    input  logic                      i_byte_vld,
    input  logic                      i_hdr_done,
    input  descgen_pkg::hdr_bytes_t   i_hdr_bytes,
    input  logic                      i_accept,
    input  logic                      i_std_flag,
    output descgen_pkg::stream_word_t o_data,
    output logic                      o_data_wr,
    output logic                      o_descriptor_valid,
    output descgen_pkg::descriptor_t  o_descriptor
);

    descgen_pkg::descriptor_t desc_nxt;

    //////////////////////////////
    // descriptor fields
    //////////////////////////////

    assign desc_nxt = {
        i_hdr_bytes,            // 71:24
        i_std_flag,             // 23
        INPORT,                 // 22:19
        `DG_LOOKUP_EN,          // 18
        `DG_OUTPORT_DEFAULT,    // 17:9
        9'd0                    // bufid, reserved
    };

    //////////////////////////////
    // output registers
    //////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_data_wr          <= 1'b0;
            o_descriptor_valid <= 1'b0;
        end else begin
            o_data_wr          <= i_byte_vld && i_accept;   // dropped frames vanish here
            o_descriptor_valid <= i_hdr_done && i_accept;
        end
    end

    always_ff @(posedge i_clk) begin
        o_data <= i_byte;
        if (i_hdr_done)
            o_descriptor <= desc_nxt;
    end

endmodule

//--- logic/descriptor_generate.sv
// descriptor generator top: header capture, admission control and forward stage
module descriptor_generate #(
    parameter descgen_pkg::inport_t INPORT = '0
) (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  descgen_pkg::stream_word_t i_data,
    input  logic                      i_data_wr,
    input  logic                      i_std_flag,
    input  descgen_pkg::ethtype_t     i_eth_type,
    input  descgen_pkg::bufcnt_t      i_free_bufid_num,
    input  descgen_pkg::bufcnt_t      i_hp_be_threshold,
    input  descgen_pkg::bufcnt_t      i_rc_threshold,
    input  descgen_pkg::bufcnt_t      i_lp_be_threshold,
    output descgen_pkg::stream_word_t o_data,
    output logic                      o_data_wr,
    output logic                      o_descriptor_valid,
    output descgen_pkg::descriptor_t  o_descriptor,
    output descgen_pkg::discard_cnt_t o_discard_cnt
);

    logic                      head;
    descgen_pkg::stream_word_t cap_byte;
    logic                      cap_byte_vld;
    logic                      hdr_done;
    descgen_pkg::hdr_bytes_t   hdr_bytes;
    logic                      accept;
    logic                      frame_std_flag;

    //////////////////////////////
    // parallel front end
    //////////////////////////////

    header_capture u_header_capture (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_data      (i_data),
        .i_data_wr   (i_data_wr),
        .o_head      (head),
        .o_byte      (cap_byte),
        .o_byte_vld  (cap_byte_vld),
        .o_hdr_done  (hdr_done),
        .o_hdr_bytes (hdr_bytes)
    );

    admission_ctrl u_admission_ctrl (
        .i_clk             (i_clk),
        .i_rst_n           (i_rst_n),
        .i_head            (head),
        .i_head_byte       (i_data[7:0]),   // class bits live here
        .i_eth_type        (i_eth_type),
        .i_std_flag        (i_std_flag),
        .i_free_bufid_num  (i_free_bufid_num),
        .i_hp_be_threshold (i_hp_be_threshold),
        .i_rc_threshold    (i_rc_threshold),
        .i_lp_be_threshold (i_lp_be_threshold),
        .o_accept          (accept),
        .o_std_flag        (frame_std_flag),
        .o_discard_cnt     (o_discard_cnt)
    );

    //////////////////////////////
    // output stage
    //////////////////////////////

    forward_stage #(.INPORT(INPORT)) u_forward_stage (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_byte             (cap_byte),
        .i_byte_vld         (cap_byte_vld),
        .i_hdr_done         (hdr_done),
        .i_hdr_bytes        (hdr_bytes),
        .i_accept           (accept),
        .i_std_flag         (frame_std_flag),
        .o_data             (o_data),
        .o_data_wr          (o_data_wr),
        .o_descriptor_valid (o_descriptor_valid),
        .o_descriptor       (o_descriptor)
    );

endmodule

//--- verification/descgen_properties.sv
// bound assertions: descriptor with data, monotonic discard counter, quiet output in reset
module descgen_properties (
    input logic                      i_clk,
    input logic                      i_rst_n,
    input logic                      i_data_wr,
    input logic                      i_descriptor_valid,
    input descgen_pkg::discard_cnt_t i_discard_cnt
);
    timeunit 1ns;
    timeprecision 1ps;

    int assert_fails = 0;

    // descriptor goes out with the sixth byte
    a_desc_with_data: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_descriptor_valid |-> i_data_wr)
        else begin
            $error("descriptor valid without a data write");
            assert_fails++;
        end

    a_cnt_monotonic: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $past(i_rst_n) |-> (i_discard_cnt >= $past(i_discard_cnt)))
        else begin
            $error("discard counter decreased");
            assert_fails++;
        end

    a_quiet_in_reset: assert property (@(posedge i_clk) !i_rst_n |-> !i_data_wr)
        else begin
            $error("data write active during reset");
            assert_fails++;
        end

endmodule

//--- verification/descgen_tb.sv
// descriptor generator testbench with xorshift stimulus, framing and admission model and checks
`include "descgen_params.svh"

module descgen_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam descgen_pkg::inport_t TB_INPORT = 4'd9;
    localparam int FRAMES  = 25;     // per test
    localparam int NTESTS  = 4;
    localparam int MAX_LEN = 12;
    localparam int DRAIN   = 4;
    // worst case per frame is the bytes plus abort idle, stray byte and two gap cycles
    localparam int LIMIT_CYC = 10 + NTESTS * (FRAMES * (MAX_LEN + 4) + DRAIN);

    logic                      i_clk = 1'b0;
    logic                      i_rst_n;
    descgen_pkg::stream_word_t i_data;
    logic                      i_data_wr;
    logic                      i_std_flag;
    descgen_pkg::ethtype_t     i_eth_type;
    descgen_pkg::bufcnt_t      i_free_bufid_num;
    descgen_pkg::bufcnt_t      i_hp_be_threshold;
    descgen_pkg::bufcnt_t      i_rc_threshold;
    descgen_pkg::bufcnt_t      i_lp_be_threshold;
    descgen_pkg::stream_word_t o_data;
    logic                      o_data_wr;
    logic                      o_descriptor_valid;
    descgen_pkg::descriptor_t  o_descriptor;
    descgen_pkg::discard_cnt_t o_discard_cnt;

    logic [31:0] rng = 32'd92436;
    int          cyc = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;

    // reference model state
    logic                      m_open = 1'b0;
    logic                      m_accept = 1'b0;
    logic                      m_flag;
    int                        m_cnt;
    descgen_pkg::hdr_bytes_t   m_hdr;
    int                        model_disc = 0;
    int                        seen_disc = 0;
    descgen_pkg::stream_word_t exp_word[$];
    int                        exp_wcyc[$];     // cycle the word must appear in
    descgen_pkg::descriptor_t  exp_desc[$];
    int                        exp_dcyc[$];
    int                        disc_cyc[$];

    descriptor_generate #(.INPORT(TB_INPORT)) i_dut (.*);

    bind descriptor_generate descgen_properties u_properties (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_data_wr          (o_data_wr),
        .i_descriptor_valid (o_descriptor_valid),
        .i_discard_cnt      (o_discard_cnt)
    );

    always #50 i_clk = ~i_clk;

    always @(posedge i_clk) cyc <= cyc + 1;

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        rng = xorshift(rng);
        return rng % n;
    endfunction

    function automatic descgen_pkg::ethtype_t pick_eth(input int mode);
        int sel;
        sel = (mode == 0) ? 0 : (mode == 1) ? 1 + rand_below(4) : rand_below(6);
        case (sel)
            0: return `DG_ETH_MAPPED;
            1: return `DG_ETH_TSMP;
            2: return `DG_ETH_PTP;
            3: return `DG_ETH_PCF;
            default: return 16'(rand_below(65536));   // mostly plain BE
        endcase
    endfunction

    task automatic compare(input string name, input logic [71:0] got, input logic [71:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h at cycle %0d", name, got, exp, cyc);
            errors++;
        end
    endtask

    // discard table by traffic class
    function automatic logic model_drop();
        logic [2:0] cls;
        cls = i_data[7:5];
        if (i_eth_type == `DG_ETH_MAPPED) begin
            if (cls == 3'd3)
                return i_free_bufid_num <= i_rc_threshold || i_free_bufid_num == 0;
            if (cls == 3'd6)
                return i_free_bufid_num <= i_rc_threshold ||
                       i_free_bufid_num <= i_hp_be_threshold || i_free_bufid_num == 0;
            return i_free_bufid_num == 0;     // time-critical
        end
        if (i_eth_type == `DG_ETH_TSMP || i_eth_type == `DG_ETH_PTP ||
            i_eth_type == `DG_ETH_PCF)
            return i_free_bufid_num <= i_hp_be_threshold;
        return i_free_bufid_num <= i_lp_be_threshold || i_free_bufid_num == 0;
    endfunction

    // framing rule applied to the word driven this cycle
    task automatic model_cycle();
        logic frame_byte;
        frame_byte = 1'b0;
        if (i_data_wr && i_data[8] && !m_open) begin
            m_open     = 1'b1;
            m_cnt      = 0;
            m_accept   = !model_drop();
            m_flag     = (i_eth_type == `DG_ETH_MAPPED) ? 1'b0 : i_std_flag;
            frame_byte = 1'b1;
            if (!m_accept) begin
                disc_cyc.push_back(cyc);
                model_disc++;
            end
        end else if (i_data_wr && m_open) begin
            frame_byte = 1'b1;
            m_open     = !i_data[8];    // tail closes
        end else if (!i_data_wr) begin
            m_open = 1'b0;              // write gap aborts
        end
        if (frame_byte && m_accept) begin
            exp_word.push_back(i_data);
            exp_wcyc.push_back(cyc + 2);
        end
        if (frame_byte && m_cnt < `DG_HDR_BYTES) begin
            m_hdr = {m_hdr[39:0], i_data[7:0]};
            m_cnt++;
            if (m_cnt == `DG_HDR_BYTES && m_accept) begin
                exp_desc.push_back({m_hdr, m_flag, TB_INPORT, 1'b1, 9'd0, 9'd0});
                exp_dcyc.push_back(cyc + 2);
            end
        end
    endtask

    task automatic drive(input logic wr, input descgen_pkg::stream_word_t w);
        i_data_wr = wr;
        i_data    = w;
        model_cycle();
        @(posedge i_clk);
        #10;
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic run_frame(input int mode);
        int len;
        int cut;
        int k;
        cut = 0;
        if (mode == 3 && rand_below(2) == 0)
            len = 2 + rand_below(4);            // shorter than the header
        else
            len = 2 + rand_below(MAX_LEN - 1);
        if (mode == 3 && len > 3 && rand_below(2) == 0)
            cut = 1 + rand_below(len - 1);      // bytes sent before the gap
        i_eth_type        = pick_eth(mode);
        i_std_flag        = 1'(rand_below(2));
        i_free_bufid_num  = (mode == 2) ? 9'(rand_below(48)) : 9'h1FF;
        i_hp_be_threshold = 9'(rand_below(48));
        i_rc_threshold    = 9'(rand_below(48));
        i_lp_be_threshold = 9'(rand_below(48));
        for (k = 0; k < len; k++) begin
            if (cut != 0 && k == cut)
                break;
            drive(1'b1, {(k == 0) || (k == len - 1), 8'(rand_below(256))});
        end
        if (cut != 0) begin
            drive(1'b0, 9'(rand_below(512)));
            drive(1'b1, {1'b0, 8'(rand_below(256))});  // stray byte while no frame is open
        end
        repeat (rand_below(3)) drive(1'b0, 9'(rand_below(512)));
    endtask

    task automatic run_test(input string name, input int mode);
        int errs_before;
        errs_before = errors;
        repeat (FRAMES) run_frame(mode);
        repeat (DRAIN) drive(1'b0, '0);
        tests++;
        $display("test %-16s frames %0d errors %0d", name, FRAMES, errors - errs_before);
    endtask

    //////////////////////////////
    // output monitor
    //////////////////////////////

    always @(negedge i_clk) begin
        logic want;
        if (i_rst_n) begin
            while (disc_cyc.size() > 0 && disc_cyc[0] + 1 <= cyc) begin
                void'(disc_cyc.pop_front());
                seen_disc++;
            end
            compare("o_discard_cnt", o_discard_cnt, seen_disc);
            want = exp_wcyc.size() > 0 && exp_wcyc[0] == cyc;
            compare("o_data_wr", o_data_wr, want);
            if (want) begin
                compare("o_data", o_data, exp_word.pop_front());
                void'(exp_wcyc.pop_front());
            end
            want = exp_dcyc.size() > 0 && exp_dcyc[0] == cyc;
            compare("o_descriptor_valid", o_descriptor_valid, want);
            if (want) begin
                compare("o_descriptor", o_descriptor, exp_desc.pop_front());
                void'(exp_dcyc.pop_front());
            end
        end
    end

    initial begin
        #(LIMIT_CYC * 200);     // twice the worst case
        $display("watchdog expired: stimulus did not complete in time");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        i_rst_n           = 1'b0;
        i_data_wr         = 1'b0;
        i_data            = '0;
        i_std_flag        = 1'b0;
        i_eth_type        = '0;
        i_free_bufid_num  = '0;
        i_hp_be_threshold = '0;
        i_rc_threshold    = '0;
        i_lp_be_threshold = '0;
        repeat (8) @(posedge i_clk);
        #10;
        i_rst_n = 1'b1;
        @(posedge i_clk);
        #10;
        run_test("mapped_ample", 0);
        run_test("standard_ample", 1);
        run_test("random_admission", 2);
        run_test("short_and_abort", 3);
        compare("o_discard_cnt", o_discard_cnt, model_disc);
        if (i_dut.u_properties.assert_fails != 0) begin
            $display("bound assertions failed %0d times", i_dut.u_properties.assert_fails);
            errors++;
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

//--- build.f
+incdir+common
common/descgen_pkg.sv
descriptor/header_capture.sv
admission/admission_ctrl.sv
logic/forward_stage.sv
logic/descriptor_generate.sv
verification/descgen_properties.sv
verification/descgen_tb.sv

//--- Bender.yml
package:
  name: descgen

export_include_dirs:
  - common

sources:
  - common/descgen_pkg.sv
  - descriptor/header_capture.sv
  - admission/admission_ctrl.sv
  - logic/forward_stage.sv
  - logic/descriptor_generate.sv
  - target: test
    files:
      - verification/descgen_properties.sv
      - verification/descgen_tb.sv
